// File: Makefile
VERILATOR  ?= verilator
TOP        ?= fat_tree_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/fat_tree_tb.sv
`timescale 1ns/1ps

module fat_tree_tb;

	localparam int num_leaves = 8;
	localparam int payload_w = 8;
	localparam int aw = tree_pkt_pkg::addr_w(num_leaves);
	localparam int pkt_w = 1 + aw + payload_w;
	localparam int clk_period = 10;
	localparam int n_tags = 1 << payload_w;
	localparam int max_in_flight = 64;
	localparam int hot_leaf = 5;
	localparam int n_iso = 11;
	localparam int n_rand = 120;
	localparam int n_hot = 64;
	localparam int watchdog_cycles = (n_iso + n_rand + n_hot + 200) * 10;
	localparam int ph_iso = 0;
	localparam int ph_rand = 1;
	localparam int ph_hot = 2;

	// self, sibling, cousin and cross-root pairs
	localparam int iso_src_tbl [n_iso] = '{0, 3, 0, 1, 6, 0, 5, 0, 7, 2, 4};
	localparam int iso_dst_tbl [n_iso] = '{0, 3, 1, 0, 7, 2, 7, 7, 0, 5, 3};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [num_leaves*pkt_w-1:0] pe_pkt_i = '0;
	logic [num_leaves*pkt_w-1:0] pe_pkt_o;
	logic [num_leaves-1:0] resend_o;
	logic [num_leaves-1:0] out_valid;

	// set by the main sequence between edges
	int phase = ph_iso;
	int quota = 0;
	int iso_src = 0;
	int iso_dst = 0;
	logic idle_chk = 1'b0;

	// owned by the traffic process
	int cycle = 0;
	int launched = 0;
	int delivered = 0;
	int hot_resends = 0;
	logic [31:0] rng = 32'h21b4_ed8b;
	logic [payload_w-1:0] next_tag = '0;
	logic busy [n_tags];
	logic outstanding [n_tags];
	logic [aw-1:0] exp_dest [n_tags];
	int inj_cycle [n_tags];
	int exp_lat [n_tags];

	int err_idle = 0;
	int err_dest = 0;
	int err_lat = 0;
	int err_score = 0;
	int err_end = 0;

	fat_tree_top #(.num_leaves(num_leaves), .payload_w(payload_w)) DUT (
		.clk     (clk),
		.reset   (reset),
		.pe_pkt_i(pe_pkt_i),
		.pe_pkt_o(pe_pkt_o),
		.resend_o(resend_o)
	);

	always #(clk_period / 2) clk = ~clk;

	for (genvar k = 0; k < num_leaves; k++) begin : g_valid
		assign out_valid[k] = pe_pkt_o[k*pkt_w + pkt_w - 1];
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ancestor level is the count of equal leading address bits, at most the deepest level
	function automatic int iso_latency(input int src, input int dst);
		int c;
		c = 0;
		while (c < aw - 1 && src[aw-1-c] == dst[aw-1-c]) begin
			c++;
		end
		return 3 + 2 * (aw - 1 - c);
	endfunction

	task automatic record_injection(input logic [pkt_w-1:0] w);
		logic [payload_w-1:0] tag;
		tag = w[payload_w-1:0];
		outstanding[tag] = 1'b1;
		exp_dest[tag] = w[payload_w +: aw];
		inj_cycle[tag] = cycle;
	endtask

	task automatic check_delivery(input int k, input logic [pkt_w-1:0] w);
		logic [payload_w-1:0] tag;
		tag = w[payload_w-1:0];
		assert (w[payload_w +: aw] == aw'(k)) else begin
			err_dest++;
			$display("Fail at %0t: pe_pkt_o[%0d] dest expected %0d, got %0d",
				$time, k, k, w[payload_w +: aw]);
		end
		assert (outstanding[tag]) else begin
			err_score++;
			$display("tag %0d arrived at leaf %0d without an open injection", tag, k);
		end
		if (outstanding[tag]) begin
			assert (exp_dest[tag] == aw'(k)) else begin
				err_score++;
				$display("Fail at %0t: pe_pkt_o leaf of tag %0d expected %0d, got %0d",
					$time, tag, exp_dest[tag], k);
			end
			if (exp_lat[tag] >= 0) begin
				assert (cycle - inj_cycle[tag] == exp_lat[tag]) else begin
					err_lat++;
					$display("Fail at %0t: pe_pkt_o[%0d] latency expected %0d, got %0d",
						$time, k, exp_lat[tag], cycle - inj_cycle[tag]);
				end
			end
			outstanding[tag] = 1'b0;
			busy[tag] = 1'b0;
		end
		// every arrival counts towards draining
		delivered++;
	endtask

	// scoreboard and per-leaf injection with retry on resend
	always @(posedge clk) begin : traffic
		logic [pkt_w-1:0] w;
		logic [pkt_w-1:0] next;
		logic [aw-1:0] dst;
		logic want;
		cycle = cycle + 1;
		if (reset) begin
			for (int t = 0; t < n_tags; t++) begin
				busy[t] = 1'b0;
				outstanding[t] = 1'b0;
			end
		end else begin
			if (phase == ph_hot && resend_o != '0) begin
				hot_resends++;
			end
			for (int k = 0; k < num_leaves; k++) begin
				w = pe_pkt_o[k*pkt_w +: pkt_w];
				if (w[pkt_w-1]) begin
					check_delivery(k, w);
				end
				w = pe_pkt_i[k*pkt_w +: pkt_w];
				next = '0;
				if (w[pkt_w-1] && resend_o[k]) begin
					next = w;
				end else begin
					if (w[pkt_w-1]) begin
						record_injection(w);
					end
					want = 1'b0;
					dst = '0;
					if (launched < quota && launched - delivered < max_in_flight) begin
						if (phase == ph_iso) begin
							want = (k == iso_src);
							dst = aw'(iso_dst);
						end else if (phase == ph_rand) begin
							rng = lcg_next(rng);
							want = (rng[31:30] != 2'b00);
							rng = lcg_next(rng);
							dst = aw'(rng[31:16] % num_leaves);
						end else begin
							want = 1'b1;
							dst = aw'(hot_leaf);
						end
					end
					if (want) begin
						while (busy[next_tag]) begin
							next_tag = next_tag + 1'b1;
						end
						busy[next_tag] = 1'b1;
						exp_lat[next_tag] = (phase == ph_iso) ? iso_latency(k, iso_dst) : -1;
						next = {1'b1, dst, next_tag};
						next_tag = next_tag + 1'b1;
						launched++;
					end
				end
				pe_pkt_i[k*pkt_w +: pkt_w] <= next;
			end
		end
	end

	// nothing leaves the tree while every leaf is quiet
	assert property (@(posedge clk) disable iff (reset)
		idle_chk |-> (out_valid == '0 && resend_o == '0))
		else begin
			err_idle++;
			$display("Fail at %0t: pe_pkt_o valid expected 0, got %b; resend_o expected 0, got %b",
				$time, $sampled(out_valid), $sampled(resend_o));
		end

	task automatic wait_drained();
		while (delivered < quota) begin
			@(negedge clk);
		end
	endtask

	initial begin : main_seq
		int left;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		idle_chk = 1'b1;
		repeat (20) @(negedge clk);
		idle_chk = 1'b0;
		for (int i = 0; i < n_iso; i++) begin
			iso_src = iso_src_tbl[i];
			iso_dst = iso_dst_tbl[i];
			quota = quota + 1;
			wait_drained();
			repeat (4) @(negedge clk);
		end
		phase = ph_rand;
		quota = quota + n_rand;
		wait_drained();
		phase = ph_hot;
		quota = quota + n_hot;
		wait_drained();
		repeat (10) @(negedge clk);
		assert (hot_resends > 0) else begin
			err_end++;
			$display("no resend_o pulse was seen during hot spot traffic");
		end
		left = 0;
		for (int t = 0; t < n_tags; t++) begin
			if (busy[t] || outstanding[t]) begin
				left++;
			end
		end
		assert (left == 0) else begin
			err_end++;
			$display("%0d packets are still outstanding after draining", left);
		end
		$display("errors: idle %0d, dest %0d, latency %0d, scoreboard %0d, end %0d",
			err_idle, err_dest, err_lat, err_score, err_end);
		if (err_idle + err_dest + err_lat + err_score + err_end == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		$display("timeout: traffic did not drain within %0d cycles", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: sources.f
verilog/tree_dir_pkg.sv
verilog/tree_pkt_pkg.sv
verilog/route_decider.sv
verilog/turn_arbiter.sv
verilog/tree_switch.sv
verilog/leaf_port.sv
verilog/fat_tree_top.sv
dv/fat_tree_tb.sv

// File: verilog/fat_tree_top.sv
`timescale 1ns/1ps

module fat_tree_top #(
	parameter int num_leaves = tree_pkt_pkg::DEF_NUM_LEAVES,
	parameter int payload_w = tree_pkt_pkg::DEF_PAYLOAD_W,
	localparam int pkt_w = 1 + tree_pkt_pkg::addr_w(num_leaves) + payload_w
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [num_leaves*pkt_w-1:0] pe_pkt_i,
	output logic [num_leaves*pkt_w-1:0] pe_pkt_o,
	output logic [num_leaves-1:0]       resend_o
);

	localparam int depth = tree_pkt_pkg::addr_w(num_leaves);

	// links numbered in heap order: root is node 1, children of h are 2h and 2h+1,
	// leaf k is node num_leaves+k
	// link_up[h] leaves node h towards its parent, link_dn[h] enters node h from above
	logic [pkt_w-1:0] link_up [2:2*num_leaves-1];
	logic [pkt_w-1:0] link_dn [2:2*num_leaves-1];

	for (genvar lv = 0; lv < depth; lv++) begin : g_level
		for (genvar n = 0; n < (1 << lv); n++) begin : g_node
			localparam int h = (1 << lv) + n;

			if (lv == 0) begin : g_root
				// no parent, up port tied off and its output unused
				tree_switch #(
					.num_leaves(num_leaves),
					.payload_w (payload_w),
					.pkt_w     (pkt_w),
					.node_addr (n),
					.level     (lv)
				) u_switch (
					.clk    (clk),
					.reset  (reset),
					.l_bus_i(link_up[2*h]),
					.r_bus_i(link_up[2*h+1]),
					.u_bus_i('0),
					.l_bus_o(link_dn[2*h]),
					.r_bus_o(link_dn[2*h+1]),
					.u_bus_o()
				);
			end else begin : g_inner
				tree_switch #(
					.num_leaves(num_leaves),
					.payload_w (payload_w),
					.pkt_w     (pkt_w),
					.node_addr (n),
					.level     (lv)
				) u_switch (
					.clk    (clk),
					.reset  (reset),
					.l_bus_i(link_up[2*h]),
					.r_bus_i(link_up[2*h+1]),
					.u_bus_i(link_dn[h]),
					.l_bus_o(link_dn[2*h]),
					.r_bus_o(link_dn[2*h+1]),
					.u_bus_o(link_up[h])
				);
			end
		end
	end

	for (genvar k = 0; k < num_leaves; k++) begin : g_leaf
		leaf_port #(
			.num_leaves(num_leaves),
			.payload_w (payload_w),
			.pkt_w     (pkt_w),
			.leaf_addr (k)
		) u_leaf (
			.clk     (clk),
			.reset   (reset),
			.bus_i   (link_dn[num_leaves+k]),
			.pe_pkt_i(pe_pkt_i[k*pkt_w +: pkt_w]),
			.bus_o   (link_up[num_leaves+k]),
			.pe_pkt_o(pe_pkt_o[k*pkt_w +: pkt_w]),
			.resend_o(resend_o[k])
		);
	end

endmodule

// File: verilog/leaf_port.sv
`timescale 1ns/1ps

module leaf_port #(
	parameter int num_leaves = tree_pkt_pkg::DEF_NUM_LEAVES,
	parameter int payload_w = tree_pkt_pkg::DEF_PAYLOAD_W,
	parameter int pkt_w = 1 + tree_pkt_pkg::addr_w(num_leaves) + payload_w,
	parameter int leaf_addr = 0
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [pkt_w-1:0] bus_i,
	input  logic [pkt_w-1:0] pe_pkt_i,
	output logic [pkt_w-1:0] bus_o,
	output logic [pkt_w-1:0] pe_pkt_o,
	output logic             resend_o
);

	localparam int aw = tree_pkt_pkg::addr_w(num_leaves);
	localparam int vp = tree_pkt_pkg::valid_pos(pkt_w);
	localparam int dl = tree_pkt_pkg::dest_lsb(payload_w);
	localparam logic [aw-1:0] own_addr = aw'(leaf_addr);

	logic accept;
	logic foreign;

	assign accept = bus_i[vp] && (bus_i[dl +: aw] == own_addr);
	assign foreign = bus_i[vp] && (bus_i[dl +: aw] != own_addr);

	// a passing packet owns the uplink this cycle, the PE has to retry
	assign resend_o = foreign;

	always_ff @(posedge clk) begin
		if (reset) begin
			pe_pkt_o <= '0;
			bus_o <= '0;
		end else begin
			pe_pkt_o <= accept ? bus_i : '0;
			bus_o <= foreign ? bus_i : pe_pkt_i;
		end
	end

	// a delivered packet is addressed to this leaf
	assert property (@(posedge clk) disable iff (reset)
		pe_pkt_o[vp] |-> (pe_pkt_o[dl +: aw] == own_addr))
		else $error("leaf_port: delivered packet not addressed to leaf %0d", leaf_addr);

endmodule

// File: verilog/route_decider.sv
`timescale 1ns/1ps

module route_decider #(
	parameter int num_leaves = tree_pkt_pkg::DEF_NUM_LEAVES,
	parameter int node_addr = 0,
	parameter int level = 0,
	localparam int aw = tree_pkt_pkg::addr_w(num_leaves)
) (
	input  logic                          valid_i,
	input  logic [aw-1:0]                 dest_i,
	output logic [tree_dir_pkg::DIR_W-1:0] dir_o
);

	if (level == 0) begin : g_root
		// root splits the tree on the top address bit
		always_comb begin
			if (!valid_i) begin
				dir_o = tree_dir_pkg::DIR_VOID;
			end else if (dest_i[aw-1]) begin
				dir_o = tree_dir_pkg::DIR_RIGHT;
			end else begin
				dir_o = tree_dir_pkg::DIR_LEFT;
			end
		end
	end else begin : g_inner
		logic [level-1:0] prefix;
		logic             prefix_hit;

		// upper address bits name the subtree below this node
		assign prefix = dest_i[aw-1 -: level];
		assign prefix_hit = (prefix == level'(node_addr));

		always_comb begin
			if (!valid_i) begin
				dir_o = tree_dir_pkg::DIR_VOID;
			end else if (!prefix_hit) begin
				// destination lives outside this subtree
				dir_o = tree_dir_pkg::DIR_UP;
			end else if (dest_i[aw-1-level]) begin
				dir_o = tree_dir_pkg::DIR_RIGHT;
			end else begin
				dir_o = tree_dir_pkg::DIR_LEFT;
			end
		end
	end

endmodule

// File: verilog/tree_dir_pkg.sv
package tree_dir_pkg;

	// width of a direction request or a mux select
	localparam int DIR_W = 2;

	// as a request: where the word wants to go
	// as a select: which input the output takes
	localparam logic [DIR_W-1:0] DIR_VOID  = 2'b00;
	localparam logic [DIR_W-1:0] DIR_LEFT  = 2'b01;
	localparam logic [DIR_W-1:0] DIR_RIGHT = 2'b10;
	localparam logic [DIR_W-1:0] DIR_UP    = 2'b11;

endpackage

// File: verilog/tree_pkt_pkg.sv
package tree_pkt_pkg;

	// default network size
	localparam int DEF_NUM_LEAVES = 8;
	localparam int DEF_PAYLOAD_W  = 8;

	// packet layout, msb first: valid, dest leaf address, payload

	// address bits needed to name one leaf
	function automatic int addr_w(input int num_leaves);
		return $clog2(num_leaves);
	endfunction

	// bit index of the valid flag
	function automatic int valid_pos(input int pkt_w);
		return pkt_w - 1;
	endfunction

	// lowest bit of the destination field, just above the payload
	function automatic int dest_lsb(input int payload_w);
		return payload_w;
	endfunction

endpackage

// File: verilog/tree_switch.sv
`timescale 1ns/1ps

module tree_switch #(
	parameter int num_leaves = tree_pkt_pkg::DEF_NUM_LEAVES,
	parameter int payload_w = tree_pkt_pkg::DEF_PAYLOAD_W,
	parameter int pkt_w = 1 + tree_pkt_pkg::addr_w(num_leaves) + payload_w,
	parameter int node_addr = 0,
	parameter int level = 0
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [pkt_w-1:0] l_bus_i,
	input  logic [pkt_w-1:0] r_bus_i,
	input  logic [pkt_w-1:0] u_bus_i,
	output logic [pkt_w-1:0] l_bus_o,
	output logic [pkt_w-1:0] r_bus_o,
	output logic [pkt_w-1:0] u_bus_o
);

	localparam int aw = tree_pkt_pkg::addr_w(num_leaves);
	localparam int vp = tree_pkt_pkg::valid_pos(pkt_w);
	localparam int dl = tree_pkt_pkg::dest_lsb(payload_w);

	logic [tree_dir_pkg::DIR_W-1:0] dir_l, dir_r, dir_u;
	logic [tree_dir_pkg::DIR_W-1:0] sel_l, sel_r, sel_u;
	logic [1:0] in_cnt;
	logic [1:0] out_cnt;

	// output mux, void gives an empty word
	function automatic logic [pkt_w-1:0] pick(input logic [tree_dir_pkg::DIR_W-1:0] sel,
			input logic [pkt_w-1:0] l_word, input logic [pkt_w-1:0] r_word,
			input logic [pkt_w-1:0] u_word);
		case (sel)
			tree_dir_pkg::DIR_LEFT:  return l_word;
			tree_dir_pkg::DIR_RIGHT: return r_word;
			tree_dir_pkg::DIR_UP:    return u_word;
			default:                 return '0;
		endcase
	endfunction

	route_decider #(.num_leaves(num_leaves), .node_addr(node_addr), .level(level)) u_dec_l (
		.valid_i(l_bus_i[vp]),
		.dest_i (l_bus_i[dl +: aw]),
		.dir_o  (dir_l)
	);

	route_decider #(.num_leaves(num_leaves), .node_addr(node_addr), .level(level)) u_dec_r (
		.valid_i(r_bus_i[vp]),
		.dest_i (r_bus_i[dl +: aw]),
		.dir_o  (dir_r)
	);

	route_decider #(.num_leaves(num_leaves), .node_addr(node_addr), .level(level)) u_dec_u (
		.valid_i(u_bus_i[vp]),
		.dest_i (u_bus_i[dl +: aw]),
		.dir_o  (dir_u)
	);

	turn_arbiter #(.level(level)) u_arb (
		.dir_l_i(dir_l),
		.dir_r_i(dir_r),
		.dir_u_i(dir_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			l_bus_o <= '0;
			r_bus_o <= '0;
			u_bus_o <= '0;
		end else begin
			l_bus_o <= pick(sel_l, l_bus_i, r_bus_i, u_bus_i);
			r_bus_o <= pick(sel_r, l_bus_i, r_bus_i, u_bus_i);
			u_bus_o <= pick(sel_u, l_bus_i, r_bus_i, u_bus_i);
		end
	end

	assign in_cnt = {1'b0, l_bus_i[vp]} + {1'b0, r_bus_i[vp]} + {1'b0, u_bus_i[vp]};
	assign out_cnt = {1'b0, l_bus_o[vp]} + {1'b0, r_bus_o[vp]} + {1'b0, u_bus_o[vp]};

	// deflection routing never drops or clones a packet
	assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (out_cnt == $past(in_cnt)))
		else $error("tree_switch: valid word count changed across the switch");

endmodule

// File: verilog/turn_arbiter.sv
`timescale 1ns/1ps

module turn_arbiter #(
	parameter int level = 0
) (
	input  logic [tree_dir_pkg::DIR_W-1:0] dir_l_i,
	input  logic [tree_dir_pkg::DIR_W-1:0] dir_r_i,
	input  logic [tree_dir_pkg::DIR_W-1:0] dir_u_i,
	output logic [tree_dir_pkg::DIR_W-1:0] sel_l_o,
	output logic [tree_dir_pkg::DIR_W-1:0] sel_r_o,
	output logic [tree_dir_pkg::DIR_W-1:0] sel_u_o
);

	if (level == 0) begin : g_root
		// two ports only, nothing ever leaves through the top
		always_comb begin
			sel_l_o = tree_dir_pkg::DIR_VOID;
			sel_r_o = tree_dir_pkg::DIR_VOID;
			sel_u_o = tree_dir_pkg::DIR_VOID;
			if (dir_l_i == tree_dir_pkg::DIR_LEFT) begin
				sel_l_o = tree_dir_pkg::DIR_LEFT;
			end
			if (dir_r_i == tree_dir_pkg::DIR_RIGHT) begin
				sel_r_o = tree_dir_pkg::DIR_RIGHT;
			end
			// crossing words, a loser bounces back where it came from
			if (dir_r_i == tree_dir_pkg::DIR_LEFT) begin
				if (sel_l_o == tree_dir_pkg::DIR_VOID) begin
					sel_l_o = tree_dir_pkg::DIR_RIGHT;
				end else begin
					sel_r_o = tree_dir_pkg::DIR_RIGHT;
				end
			end
			if (dir_l_i == tree_dir_pkg::DIR_RIGHT) begin
				if (sel_r_o == tree_dir_pkg::DIR_VOID) begin
					sel_r_o = tree_dir_pkg::DIR_LEFT;
				end else begin
					sel_l_o = tree_dir_pkg::DIR_LEFT;
				end
			end
		end
	end else begin : g_inner
		always_comb begin
			sel_l_o = tree_dir_pkg::DIR_VOID;
			sel_r_o = tree_dir_pkg::DIR_VOID;
			sel_u_o = tree_dir_pkg::DIR_VOID;

			// turnback words keep their own link
			if (dir_l_i == tree_dir_pkg::DIR_LEFT) begin
				sel_l_o = tree_dir_pkg::DIR_LEFT;
			end
			if (dir_r_i == tree_dir_pkg::DIR_RIGHT) begin
				sel_r_o = tree_dir_pkg::DIR_RIGHT;
			end

			// downlink, deflected back up if a turnback holds the link
			if (dir_u_i == tree_dir_pkg::DIR_UP) begin
				sel_u_o = tree_dir_pkg::DIR_UP;
			end else if (dir_u_i == tree_dir_pkg::DIR_LEFT) begin
				if (sel_l_o == tree_dir_pkg::DIR_VOID) begin
					sel_l_o = tree_dir_pkg::DIR_UP;
				end else begin
					sel_u_o = tree_dir_pkg::DIR_UP;
				end
			end else if (dir_u_i == tree_dir_pkg::DIR_RIGHT) begin
				if (sel_r_o == tree_dir_pkg::DIR_VOID) begin
					sel_r_o = tree_dir_pkg::DIR_UP;
				end else begin
					sel_u_o = tree_dir_pkg::DIR_UP;
				end
			end

			// left input, side link before uplink
			// the last choice is always free, at most two outputs are taken
			if (dir_l_i == tree_dir_pkg::DIR_RIGHT) begin
				if (sel_r_o == tree_dir_pkg::DIR_VOID) begin
					sel_r_o = tree_dir_pkg::DIR_LEFT;
				end else if (sel_l_o == tree_dir_pkg::DIR_VOID) begin
					sel_l_o = tree_dir_pkg::DIR_LEFT;
				end else begin
					sel_u_o = tree_dir_pkg::DIR_LEFT;
				end
			end else if (dir_l_i == tree_dir_pkg::DIR_UP) begin
				if (sel_u_o == tree_dir_pkg::DIR_VOID) begin
					sel_u_o = tree_dir_pkg::DIR_LEFT;
				end else if (sel_l_o == tree_dir_pkg::DIR_VOID) begin
					sel_l_o = tree_dir_pkg::DIR_LEFT;
				end else begin
					sel_r_o = tree_dir_pkg::DIR_LEFT;
				end
			end

			// right input takes whatever is left over
			if (dir_r_i == tree_dir_pkg::DIR_LEFT) begin
				if (sel_l_o == tree_dir_pkg::DIR_VOID) begin
					sel_l_o = tree_dir_pkg::DIR_RIGHT;
				end else if (sel_r_o == tree_dir_pkg::DIR_VOID) begin
					sel_r_o = tree_dir_pkg::DIR_RIGHT;
				end else begin
					sel_u_o = tree_dir_pkg::DIR_RIGHT;
				end
			end else if (dir_r_i == tree_dir_pkg::DIR_UP) begin
				if (sel_u_o == tree_dir_pkg::DIR_VOID) begin
					sel_u_o = tree_dir_pkg::DIR_RIGHT;
				end else if (sel_r_o == tree_dir_pkg::DIR_VOID) begin
					sel_r_o = tree_dir_pkg::DIR_RIGHT;
				end else begin
					sel_l_o = tree_dir_pkg::DIR_RIGHT;
				end
			end
		end
	end

	// one input feeds at most one output
	always_comb begin
		if (sel_l_o != tree_dir_pkg::DIR_VOID) begin
			assert (sel_l_o != sel_r_o && sel_l_o != sel_u_o)
				else $error("turn_arbiter: input selected twice by left output");
		end
		if (sel_r_o != tree_dir_pkg::DIR_VOID) begin
			assert (sel_r_o != sel_u_o)
				else $error("turn_arbiter: input selected twice by right output");
		end
	end

endmodule
